// ==== osd_video_pkg.sv ====
// video word package with the sync field layout and blend widths of the stream
package osd_video_pkg;

  //////////////////////////////////////////////////
  // sync field

  // control bits sitting above the three colour channels
  localparam int SYNC_BITS = 4;

  // positions inside the sync group, counted above the colour bits
  // vsync is the top bit, hsync the second lowest
  localparam int VSYNC_POS = 3;
  localparam int HSYNC_POS = 1;

  //////////////////////////////////////////////////
  // background blend

  // upper bits of each channel taken over by the background colour
  localparam int BLEND_BITS = 3;

  // one palette entry holds red, green and blue msbs in that order
  localparam int PALETTE_BITS = 3 * BLEND_BITS;

endpackage

// ==== osd_layout_pkg.sv ====
// layout package with the overlay window geometry, cell grid and colour palette
package osd_layout_pkg;

  //////////////////////////////////////////////////
  // geometry in scaled units

  // one attribute cell
  localparam int CELL_W = 4;
  localparam int CELL_H = 2;

  // attribute grid
  localparam int GRID_COLS = 8;
  localparam int GRID_ROWS = 4;

  localparam int WIN_H = GRID_COLS * CELL_W;
  localparam int WIN_V = GRID_ROWS * CELL_H;

  // separation line rows, relative to the window top
  localparam int SEP_LINE0 = 1;
  localparam int SEP_LINE1 = 6;

  //////////////////////////////////////////////////
  // colours and types

  typedef logic [1:0] bg_sel_t;

  typedef logic [$clog2(GRID_COLS)-1:0] cell_col_t;
  typedef logic [$clog2(GRID_ROWS)-1:0] cell_row_t;

  // entry 0 is the default dark blue, then black, grey and white
  localparam logic [3:0][osd_video_pkg::PALETTE_BITS-1:0] bg_palette = {
    9'b111_111_111,
    9'b011_011_011,
    9'b000_000_000,
    9'b000_000_010
  };

  localparam logic [osd_video_pkg::PALETTE_BITS-1:0] SEP_LINE_COLOR = 9'b110_110_110;

  typedef struct packed {
    logic in_window;
    logic on_sep_line;
    logic window_line;
  } region_flags_t;

endpackage

// ==== osd_raster_if.sv ====
// raster position bundle between the counter stage and the region decode stage
`timescale 1ns/100ps

interface osd_raster_if #(
  parameter int vcnt_width = 8,
  parameter int hcnt_width = 10
);

  // scaled position of the word now in stage 1
  logic [vcnt_width-1:0] vcnt;
  logic [hcnt_width-1:0] hcnt;

  // window origin, latched at frame start
  logic [vcnt_width-1:0] win_vstart;
  logic [hcnt_width-1:0] win_hstart;

  logic pos_valid;

  modport counter (output vcnt, hcnt, win_vstart, win_hstart, pos_valid);
  modport decode  (input  vcnt, hcnt, win_vstart, win_hstart, pos_valid);

endinterface

// ==== osd_raster_counter.sv ====
// raster counter stage that detects sync edges and tracks the scaled pixel position
`timescale 1ns/100ps

module osd_raster_counter #(
  parameter int color_width = 8,
  parameter int vcnt_width  = 8,
  parameter int hcnt_width  = 10
) (
  input  logic                                                VCLK,
  input  logic                                                nVRST,
  input  logic                                                vdata_valid_i,
  input  logic [3*color_width+osd_video_pkg::SYNC_BITS-1:0]   vdata_i,
  input  logic [2:0]                                          osd_vscale_i,
  input  logic [1:0]                                          osd_hscale_i,
  input  logic [vcnt_width-1:0]                               osd_voffset_i,
  input  logic [hcnt_width-1:0]                               osd_hoffset_i,
  osd_raster_if.counter                                       raster
);

  import osd_video_pkg::*;

  logic       hsync_cur;
  logic       vsync_cur;
  logic       hsync_pre;
  logic       vsync_pre;
  logic       hsync_fall;
  logic       vsync_fall;
  logic [2:0] vcnt_dly;
  logic [1:0] hcnt_dly;

  assign hsync_cur = vdata_i[3*color_width+HSYNC_POS];
  assign vsync_cur = vdata_i[3*color_width+VSYNC_POS];

  // both syncs are active low, a frame or line starts on the falling edge
  assign hsync_fall = hsync_pre & ~hsync_cur;
  assign vsync_fall = vsync_pre & ~vsync_cur;

  //////////////////////////////////////////////////
  // counters, only valid words move them

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      hsync_pre         <= 1'b0;
      vsync_pre         <= 1'b0;
      vcnt_dly          <= '0;
      hcnt_dly          <= '0;
      raster.vcnt       <= '0;
      raster.hcnt       <= '0;
      raster.win_vstart <= '0;
      raster.win_hstart <= '0;
      raster.pos_valid  <= 1'b0;
    end else begin
      raster.pos_valid <= vdata_valid_i;
      if (vdata_valid_i) begin
        hsync_pre <= hsync_cur;
        vsync_pre <= vsync_cur;

        // vertical, frame start wins over a line start on the same word
        if (vsync_fall) begin
          raster.win_vstart <= osd_voffset_i;
          raster.win_hstart <= osd_hoffset_i;
          vcnt_dly          <= '0;
          raster.vcnt       <= '0;
        end else if (hsync_fall) begin
          if (vcnt_dly >= osd_vscale_i) begin
            vcnt_dly    <= '0;
            raster.vcnt <= raster.vcnt + 1'b1;
          end else begin
            vcnt_dly <= vcnt_dly + 3'd1;
          end
        end

        // horizontal
        if (hsync_fall) begin
          hcnt_dly    <= '0;
          raster.hcnt <= '0;
        end else if (hcnt_dly >= osd_hscale_i) begin
          hcnt_dly    <= '0;
          raster.hcnt <= raster.hcnt + 1'b1;
        end else begin
          hcnt_dly <= hcnt_dly + 2'd1;
        end
      end
    end
  end

  // each update leaves the delay counter within the scale it counted against
  a_hcnt_dly_in_scale: assert property (@(posedge VCLK) disable iff (!nVRST)
    vdata_valid_i |=> (hcnt_dly <= $past(osd_hscale_i)))
    else $error("horizontal delay counter above scale");

  a_vcnt_dly_in_scale: assert property (@(posedge VCLK) disable iff (!nVRST)
    (vdata_valid_i && hsync_fall) |=> (vcnt_dly <= $past(osd_vscale_i)))
    else $error("vertical delay counter above scale");

endmodule

// ==== osd_region_decode.sv ====
// region decode stage that finds the window, separation lines and attribute cell
`timescale 1ns/100ps

module osd_region_decode #(
  parameter int vcnt_width = 8,
  parameter int hcnt_width = 10
) (
  input  logic                          VCLK,
  input  logic                          nVRST,
  osd_raster_if.decode                  raster,
  output osd_layout_pkg::region_flags_t flags_o,
  output osd_layout_pkg::cell_col_t     rd_col_o,
  output osd_layout_pkg::cell_row_t     rd_row_o,
  output logic                          osd_active_o
);

  import osd_layout_pkg::*;

  logic [vcnt_width:0]   vstop;
  logic [hcnt_width:0]   hstop;
  logic [vcnt_width-1:0] vrel;
  logic [hcnt_width-1:0] hrel;
  logic                  in_v;
  logic                  in_h;
  logic                  on_sep;

  // one extra bit so the window end cannot wrap around
  assign vstop = (vcnt_width+1)'(raster.win_vstart) + (vcnt_width+1)'(WIN_V);
  assign hstop = (hcnt_width+1)'(raster.win_hstart) + (hcnt_width+1)'(WIN_H);

  assign in_v = (raster.vcnt >= raster.win_vstart) &&
                ((vcnt_width+1)'(raster.vcnt) < vstop);
  assign in_h = (raster.hcnt >= raster.win_hstart) &&
                ((hcnt_width+1)'(raster.hcnt) < hstop);

  // position inside the window
  assign vrel = raster.vcnt - raster.win_vstart;
  assign hrel = raster.hcnt - raster.win_hstart;

  assign on_sep = (vrel == vcnt_width'(SEP_LINE0)) ||
                  (vrel == vcnt_width'(SEP_LINE1));

  //////////////////////////////////////////////////
  // stage 2 registers

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      flags_o  <= '0;
      rd_col_o <= '0;
      rd_row_o <= '0;
    end else begin
      // only valid words get overlay pixels
      flags_o.in_window   <= raster.pos_valid && in_v && in_h;
      flags_o.on_sep_line <= raster.pos_valid && in_v && in_h && on_sep;
      flags_o.window_line <= in_v;
      // address is don't care outside the window
      rd_col_o <= cell_col_t'(hrel / CELL_W);
      rd_row_o <= cell_row_t'(vrel / CELL_H);
    end
  end

  assign osd_active_o = flags_o.window_line;

endmodule

// ==== osd_attr_ram.sv ====
// attribute memory that holds one background selection per character cell
`timescale 1ns/100ps

module osd_attr_ram (
  input  logic                      VCLK,
  input  logic                      nVRST,
  input  logic                      we_i,
  input  osd_layout_pkg::cell_col_t wr_col_i,
  input  osd_layout_pkg::cell_row_t wr_row_i,
  input  osd_layout_pkg::bg_sel_t   wr_sel_i,
  input  osd_layout_pkg::cell_col_t rd_col_i,
  input  osd_layout_pkg::cell_row_t rd_row_i,
  output osd_layout_pkg::bg_sel_t   rd_sel_o
);

  import osd_layout_pkg::*;

  // cells start out at the default background
  bg_sel_t attr_mem [GRID_ROWS][GRID_COLS] = '{default: '0};

  //////////////////////////////////////////////////
  // write port

  always_ff @(posedge VCLK) begin
    if (we_i) begin
      attr_mem[wr_row_i][wr_col_i] <= wr_sel_i;
    end
  end

  //////////////////////////////////////////////////
  // read port

  // a read on the write edge still returns the old cell
  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      rd_sel_o <= '0;
    end else begin
      rd_sel_o <= attr_mem[rd_row_i][rd_col_i];
    end
  end

  a_wr_in_grid: assert property (@(posedge VCLK) disable iff (!nVRST)
    we_i |-> (!$isunknown({wr_col_i, wr_row_i}) &&
              (int'(wr_col_i) < GRID_COLS) && (int'(wr_row_i) < GRID_ROWS)))
    else $error("attribute write outside the cell grid");

endmodule

// ==== osd_delay_line.sv ====
// register chain that delays any payload by a fixed number of cycles
`timescale 1ns/100ps

module osd_delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     VCLK,
  input  logic     nVRST,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t stage_q [depth];

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[depth-1];

endmodule

// ==== osd_pixel_mixer.sv ====
// pixel mixer stage that blends the overlay colour into the delayed video word
`timescale 1ns/100ps

module osd_pixel_mixer #(
  parameter int color_width = 8
) (
  input  logic                                              VCLK,
  input  logic                                              nVRST,
  input  logic                                              show_osd_i,
  input  osd_layout_pkg::region_flags_t                     flags_i,
  input  osd_layout_pkg::bg_sel_t                           bg_sel_i,
  input  logic                                              vdata_valid_i,
  input  logic [3*color_width+osd_video_pkg::SYNC_BITS-1:0] vdata_i,
  output logic                                              vdata_valid_o,
  output logic [3*color_width+osd_video_pkg::SYNC_BITS-1:0] vdata_o
);

  import osd_video_pkg::*;
  import osd_layout_pkg::*;

  localparam int CW3 = 3 * color_width;

  logic [CW3-1:0]          color_in;
  logic [CW3-1:0]          color_blend;
  logic [CW3-1:0]          color_sep;
  logic [CW3-1:0]          color_next;
  logic [PALETTE_BITS-1:0] bg_color;

  assign color_in = vdata_i[CW3-1:0];
  assign bg_color = bg_palette[bg_sel_i];

  // channel 2 is red, 1 green, 0 blue
  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      // background takes the msbs, the old msbs shift down
      color_blend[ch*color_width+color_width-1 -: BLEND_BITS] =
        bg_color[ch*BLEND_BITS+BLEND_BITS-1 -: BLEND_BITS];
      color_blend[ch*color_width +: color_width-BLEND_BITS] =
        color_in[ch*color_width+BLEND_BITS +: color_width-BLEND_BITS];
      color_sep[ch*color_width+color_width-1 -: BLEND_BITS] =
        SEP_LINE_COLOR[ch*BLEND_BITS+BLEND_BITS-1 -: BLEND_BITS];
      color_sep[ch*color_width +: color_width-BLEND_BITS] = '0;
    end
  end

  always_comb begin
    if (show_osd_i && flags_i.in_window) begin
      color_next = flags_i.on_sep_line ? color_sep : color_blend;
    end else begin
      color_next = color_in;
    end
  end

  //////////////////////////////////////////////////
  // output register

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      vdata_valid_o <= 1'b0;
      vdata_o       <= '0;
    end else begin
      // valid and sync bits go through untouched
      vdata_valid_o <= vdata_valid_i;
      vdata_o       <= {vdata_i[CW3+SYNC_BITS-1:CW3], color_next};
    end
  end

  a_valid_known: assert property (@(posedge VCLK) disable iff (!nVRST)
    !$isunknown(vdata_valid_o))
    else $error("vdata_valid_o unknown after reset");

endmodule

// ==== osd_injection_top.sv ====
// osd injection top that overlays a palette window on the video stream
`timescale 1ns/100ps

module osd_injection_top #(
  parameter int color_width = 8,
  parameter int vcnt_width  = 8,
  parameter int hcnt_width  = 10
) (
  input  logic                                              VCLK,
  input  logic                                              nVRST,
  input  logic                                              show_osd_i,
  input  logic [2:0]                                        osd_vscale_i,
  input  logic [1:0]                                        osd_hscale_i,
  input  logic [vcnt_width-1:0]                             osd_voffset_i,
  input  logic [hcnt_width-1:0]                             osd_hoffset_i,
  input  logic                                              attr_we_i,
  input  osd_layout_pkg::cell_col_t                         attr_col_i,
  input  osd_layout_pkg::cell_row_t                         attr_row_i,
  input  osd_layout_pkg::bg_sel_t                           attr_sel_i,
  input  logic                                              vdata_valid_i,
  input  logic [3*color_width+osd_video_pkg::SYNC_BITS-1:0] vdata_i,
  output logic                                              vdata_valid_o,
  output logic [3*color_width+osd_video_pkg::SYNC_BITS-1:0] vdata_o,
  output logic                                              osd_active_o
);

  import osd_video_pkg::*;
  import osd_layout_pkg::*;

  typedef struct packed {
    logic                                valid;
    logic [3*color_width+SYNC_BITS-1:0] data;
  } vword_t;

  vword_t        vword_in;
  vword_t        vword_dly;
  region_flags_t flags_s2;
  region_flags_t flags_s3;
  cell_col_t     rd_col;
  cell_row_t     rd_row;
  bg_sel_t       bg_sel;

  osd_raster_if #(.vcnt_width(vcnt_width), .hcnt_width(hcnt_width)) raster_if ();

  assign vword_in = '{valid: vdata_valid_i, data: vdata_i};

  //////////////////////////////////////////////////
  // stages 1 to 3

  osd_raster_counter #(
    .color_width(color_width), .vcnt_width(vcnt_width), .hcnt_width(hcnt_width)
  ) raster_counter_u (
    .VCLK(VCLK), .nVRST(nVRST), .vdata_valid_i(vdata_valid_i), .vdata_i(vdata_i),
    .osd_vscale_i(osd_vscale_i), .osd_hscale_i(osd_hscale_i),
    .osd_voffset_i(osd_voffset_i), .osd_hoffset_i(osd_hoffset_i), .raster(raster_if)
  );

  osd_region_decode #(.vcnt_width(vcnt_width), .hcnt_width(hcnt_width)) region_decode_u (
    .VCLK(VCLK), .nVRST(nVRST), .raster(raster_if), .flags_o(flags_s2),
    .rd_col_o(rd_col), .rd_row_o(rd_row), .osd_active_o(osd_active_o)
  );

  osd_attr_ram attr_ram_u (
    .VCLK(VCLK), .nVRST(nVRST), .we_i(attr_we_i), .wr_col_i(attr_col_i),
    .wr_row_i(attr_row_i), .wr_sel_i(attr_sel_i), .rd_col_i(rd_col),
    .rd_row_i(rd_row), .rd_sel_o(bg_sel)
  );

  // video word waits three cycles, flags wait one for the ram read
  osd_delay_line #(.payload_t(vword_t), .depth(3)) vword_delay_u (
    .VCLK(VCLK), .nVRST(nVRST), .d_i(vword_in), .q_o(vword_dly)
  );

  osd_delay_line #(.payload_t(region_flags_t), .depth(1)) flags_delay_u (
    .VCLK(VCLK), .nVRST(nVRST), .d_i(flags_s2), .q_o(flags_s3)
  );

  //////////////////////////////////////////////////
  // stage 4

  osd_pixel_mixer #(.color_width(color_width)) pixel_mixer_u (
    .VCLK(VCLK), .nVRST(nVRST), .show_osd_i(show_osd_i), .flags_i(flags_s3),
    .bg_sel_i(bg_sel), .vdata_valid_i(vword_dly.valid), .vdata_i(vword_dly.data),
    .vdata_valid_o(vdata_valid_o), .vdata_o(vdata_o)
  );

endmodule

// ==== tb_osd_injection.sv ====
// testbench for the osd injection top with frame table, raster generator and reference model
`timescale 1ns/100ps

module tb_osd_injection;

  import osd_video_pkg::*;
  import osd_layout_pkg::*;

  localparam int COLOR_W   = 8;
  localparam int WORD_W    = 3 * COLOR_W + SYNC_BITS;
  localparam int LINES     = 24;
  localparam int WORDS     = 48;
  localparam int N_FRAMES  = 5;
  localparam int FRAME_CYC = LINES * WORDS + GRID_ROWS * GRID_COLS + 8;
  localparam int MAX_CYC   = 2 * N_FRAMES * FRAME_CYC + 200;

  // voffset, hoffset, vscale, hscale, show, pattern, window lines seen at mid-line
  typedef struct packed {
    logic [7:0] voff;
    logic [9:0] hoff;
    logic [2:0] vscale;
    logic [1:0] hscale;
    logic       show;
    logic [1:0] pat;
    logic [5:0] win_lines;
  } frame_entry_t;

  frame_entry_t frame_tab [N_FRAMES] = '{
    '{8'd2, 10'd6,  3'd0, 2'd0, 1'b0, 2'd0, 6'd8},
    '{8'd3, 10'd10, 3'd0, 2'd0, 1'b1, 2'd1, 6'd8},
    '{8'd1, 10'd2,  3'd1, 2'd0, 1'b1, 2'd2, 6'd16},
    '{8'd0, 10'd1,  3'd2, 2'd1, 1'b1, 2'd3, 6'd24},
    '{8'd5, 10'd12, 3'd0, 2'd0, 1'b1, 2'd0, 6'd8}
  };

  logic VCLK, nVRST, show_osd_i, attr_we_i, vdata_valid_i, vdata_valid_o, osd_active_o;
  logic [2:0] osd_vscale_i;
  logic [1:0] osd_hscale_i;
  logic [7:0] osd_voffset_i;
  logic [9:0] osd_hoffset_i;
  cell_col_t attr_col_i;
  cell_row_t attr_row_i;
  bg_sel_t attr_sel_i;
  logic [WORD_W-1:0] vdata_i, vdata_o;

  logic [31:0] rng;
  int errors, checks, active_lines, cycle_count;
  int m_hpos, m_vline, m_vstart, m_hstart;
  logic m_hs_pre, m_vs_pre;
  frame_entry_t cur;
  bg_sel_t ram_model [GRID_ROWS][GRID_COLS];
  logic [WORD_W:0] word_q [$];
  logic [1:0] act_q [$];
  logic [WORD_W:0] exp_word;
  logic [1:0] exp_act;

  osd_injection_top #(.color_width(COLOR_W), .vcnt_width(8), .hcnt_width(10)) UUT (
    .VCLK(VCLK), .nVRST(nVRST), .show_osd_i(show_osd_i), .osd_vscale_i(osd_vscale_i),
    .osd_hscale_i(osd_hscale_i), .osd_voffset_i(osd_voffset_i), .osd_hoffset_i(osd_hoffset_i),
    .attr_we_i(attr_we_i), .attr_col_i(attr_col_i), .attr_row_i(attr_row_i),
    .attr_sel_i(attr_sel_i), .vdata_valid_i(vdata_valid_i), .vdata_i(vdata_i),
    .vdata_valid_o(vdata_valid_o), .vdata_o(vdata_o), .osd_active_o(osd_active_o)
  );

  initial begin
    VCLK = 1'b0;
    forever #4 VCLK = ~VCLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bg_sel_t pattern_sel(input int pat, input int row, input int col,
                                          input logic [31:0] rnd);
    case (pat)
      0: return bg_sel_t'((row + col) % 4);
      1: return bg_sel_t'(col / 2);
      2: return bg_sel_t'(3 - row);
      default: return rnd[1:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // reference model

  task automatic predict(input logic valid, input logic [WORD_W-1:0] data, input logic mid);
    logic hs, vs, hfall, in_v, in_h, sep;
    int vcnt, hcnt;
    bg_sel_t sel;
    logic [PALETTE_BITS-1:0] col9;
    logic [COLOR_W-BLEND_BITS-1:0] low;
    logic [WORD_W-1:0] exp_data;
    hs = data[3*COLOR_W+HSYNC_POS];
    vs = data[3*COLOR_W+VSYNC_POS];
    hfall = m_hs_pre && !hs;
    if (valid) begin
      // frame start takes priority over the line start
      if (m_vs_pre && !vs) begin
        m_vline  = 0;
        m_vstart = int'(cur.voff);
        m_hstart = int'(cur.hoff);
      end else if (hfall) begin
        m_vline++;
      end
      m_hpos   = hfall ? 0 : m_hpos + 1;
      m_hs_pre = hs;
      m_vs_pre = vs;
    end
    vcnt = m_vline / (int'(cur.vscale) + 1);
    hcnt = m_hpos / (int'(cur.hscale) + 1);
    in_v = (vcnt >= m_vstart) && (vcnt < m_vstart + WIN_V);
    in_h = (hcnt >= m_hstart) && (hcnt < m_hstart + WIN_H);
    sep  = (vcnt - m_vstart == SEP_LINE0) || (vcnt - m_vstart == SEP_LINE1);
    exp_data = data;
    if (valid && cur.show && in_v && in_h) begin
      sel  = ram_model[(vcnt - m_vstart) / CELL_H][(hcnt - m_hstart) / CELL_W];
      col9 = sep ? SEP_LINE_COLOR : bg_palette[sel];
      for (int ch = 0; ch < 3; ch++) begin
        low = sep ? '0 : data[ch*COLOR_W+BLEND_BITS +: COLOR_W-BLEND_BITS];
        exp_data[ch*COLOR_W +: COLOR_W] = {col9[ch*BLEND_BITS +: BLEND_BITS], low};
      end
    end
    word_q.push_back({valid, exp_data});
    act_q.push_back({mid, in_v});
  endtask

  //////////////////////////////////////////////////
  // stimulus

  task automatic step_cycle(input logic valid, input logic [WORD_W-1:0] data, input logic we,
                            input int row, input int col, input bg_sel_t sel, input logic mid);
    @(posedge VCLK);
    show_osd_i    <= cur.show;
    osd_vscale_i  <= cur.vscale;
    osd_hscale_i  <= cur.hscale;
    osd_voffset_i <= cur.voff;
    osd_hoffset_i <= cur.hoff;
    attr_we_i     <= we;
    attr_row_i    <= cell_row_t'(row);
    attr_col_i    <= cell_col_t'(col);
    attr_sel_i    <= sel;
    vdata_valid_i <= valid;
    vdata_i       <= data;
    if (we) begin
      ram_model[row][col] = sel;
    end
    predict(valid, data, mid);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      rng = xorshift32(rng);
      step_cycle(1'b0, rng[WORD_W-1:0], 1'b0, 0, 0, '0, 1'b0);
    end
  endtask

  task automatic run_frame(input int f);
    logic [WORD_W-1:0] data;
    cur = frame_tab[f];
    for (int r = 0; r < GRID_ROWS; r++) begin
      for (int c = 0; c < GRID_COLS; c++) begin
        rng = xorshift32(rng);
        step_cycle(1'b0, '0, 1'b1, r, c, pattern_sel(int'(cur.pat), r, c, rng), 1'b0);
      end
    end
    idle_cycles(2);
    // blanking word with both syncs high arms the edge detectors once
    if (f == 0) begin
      rng = xorshift32(rng);
      step_cycle(1'b1, {4'hf, rng[3*COLOR_W-1:0]}, 1'b0, 0, 0, '0, 1'b0);
    end
    active_lines = 0;
    for (int ln = 0; ln < LINES; ln++) begin
      for (int w = 0; w < WORDS; w++) begin
        rng = xorshift32(rng);
        if (rng[31:29] == 3'd0) begin
          idle_cycles(1);
        end
        rng = xorshift32(rng);
        data = rng[WORD_W-1:0];
        data[3*COLOR_W+VSYNC_POS] = (ln != 0);
        data[3*COLOR_W+HSYNC_POS] = (w >= 4);
        step_cycle(1'b1, data, 1'b0, 0, 0, '0, w == WORDS / 2);
      end
    end
    // drain the pipeline before the next frame settings
    idle_cycles(4);
    if (active_lines != int'(cur.win_lines)) begin
      errors++;
      $display("FAILED at %0t ns: osd_active_o window lines expected %0d got %0d",
               $time, cur.win_lines, active_lines);
    end
  endtask

  //////////////////////////////////////////////////
  // output checks, sampled away from the active edge

  always @(negedge VCLK) begin
    if (word_q.size() == 5) begin
      exp_word = word_q.pop_front();
      checks++;
      if (vdata_valid_o !== exp_word[WORD_W]) begin
        errors++;
        $display("FAILED at %0t ns: vdata_valid_o expected %b got %b",
                 $time, exp_word[WORD_W], vdata_valid_o);
      end
      if (vdata_o !== exp_word[WORD_W-1:0]) begin
        errors++;
        $display("FAILED at %0t ns: vdata_o expected %h got %h",
                 $time, exp_word[WORD_W-1:0], vdata_o);
      end
    end
    if (act_q.size() == 3) begin
      exp_act = act_q.pop_front();
      if (exp_act[1]) begin
        checks++;
        if (osd_active_o === 1'b1) begin
          active_lines++;
        end
        if (osd_active_o !== exp_act[0]) begin
          errors++;
          $display("FAILED at %0t ns: osd_active_o expected %b got %b",
                   $time, exp_act[0], osd_active_o);
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYC) begin
      @(posedge VCLK);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    nVRST = 1'b0;
    show_osd_i = 1'b0;
    osd_vscale_i = '0;
    osd_hscale_i = '0;
    osd_voffset_i = '0;
    osd_hoffset_i = '0;
    attr_we_i = 1'b0;
    attr_col_i = '0;
    attr_row_i = '0;
    attr_sel_i = '0;
    vdata_valid_i = 1'b0;
    vdata_i = '0;
    cur = '0;
    rng = 32'hc75d3176;
    errors = 0;
    checks = 0;
    active_lines = 0;
    m_hpos = 0;
    m_vline = 0;
    m_vstart = 0;
    m_hstart = 0;
    m_hs_pre = 1'b0;
    m_vs_pre = 1'b0;
    repeat (7) @(posedge VCLK);
    @(negedge VCLK);
    if ({vdata_valid_o, osd_active_o, vdata_o} !== '0) begin
      errors++;
      $display("FAILED at %0t ns: {vdata_valid_o, osd_active_o, vdata_o} expected 0 got %h",
               $time, {vdata_valid_o, osd_active_o, vdata_o});
    end
    @(posedge VCLK);
    nVRST <= 1'b1;
    for (int f = 0; f < N_FRAMES; f++) begin
      run_frame(f);
    end
    @(negedge VCLK);
    @(posedge VCLK);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
osd_video_pkg.sv
osd_layout_pkg.sv
osd_raster_if.sv
osd_raster_counter.sv
osd_region_decode.sv
osd_attr_ram.sv
osd_delay_line.sv
osd_pixel_mixer.sv
osd_injection_top.sv
tb_osd_injection.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_osd_injection
FILELIST   = compile.f
OBJDIR     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
